/* common/mdu_pkg.sv */
////////////////////////////////////////////////////////////
// Shared widths and encodings for the multiply/divide unit
// The half-word split assumes a 32-bit data word
////////////////////////////////////////////////////////////

package mdu_pkg;

  // Data word and half-word operand widths
  parameter int unsigned xlen   = 32;
  parameter int unsigned half_w = 16;

  // Multiplier accumulator carries two extra bits above the word
  parameter int unsigned acc_w = xlen + 2;

  // Divider bit counter spans 31 down to 0
  parameter int unsigned cnt_w = 5;

  // Operator class from the decoder
  typedef enum logic [1:0] {
    MD_OP_MULL,
    MD_OP_MULH,
    MD_OP_DIV,
    MD_OP_REM
  } md_op_e;

  // Long division sequence
  typedef enum logic [2:0] {
    DIV_IDLE,
    DIV_ABS_A,
    DIV_ABS_B,
    DIV_COMP,
    DIV_LAST,
    DIV_SIGN,
    DIV_FINISH
  } div_state_e;

endpackage

/* filelist.f */
+incdir+verif
common/mdu_pkg.sv
hw/mult/mdu_mult_fast.sv
hw/div/mdu_div_ctrl.sv
hw/div/mdu_div_datapath.sv
hw/mdu_top.sv
verif/mdu_tb.sv

/* hw/div/mdu_div_ctrl.sv */
////////////////////////////////////////////////////////////
// Long division sequencer, 37 cycles or 2 on a zero divisor
// op_b_i is sampled for the zero test only in IDLE
////////////////////////////////////////////////////////////

module mdu_div_ctrl (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      div_en_i,
  input  logic                      ready_i,
  input  logic [mdu_pkg::xlen-1:0]  op_b_i,
  output mdu_pkg::div_state_e       state_o,
  output logic [mdu_pkg::cnt_w-1:0] count_o,
  output logic                      step_o,
  output logic                      valid_o
);

  // First quotient bit and the last COMP iteration
  localparam logic [mdu_pkg::cnt_w-1:0] cnt_first = '1;
  localparam logic [mdu_pkg::cnt_w-1:0] cnt_one   = {{(mdu_pkg::cnt_w - 1){1'b0}}, 1'b1};

  mdu_pkg::div_state_e       state_q, state_d;
  logic [mdu_pkg::cnt_w-1:0] count_q, count_d;
  logic                      b_zero;
  logic                      hold;

  assign b_zero = (op_b_i == '0);

  always_comb begin
    state_d = state_q;
    count_d = count_q;
    valid_o = 1'b0;
    hold    = 1'b0;

    unique case (state_q)
      mdu_pkg::DIV_IDLE: begin
        count_d = cnt_first;
        // Zero divisor results are already preloaded by the datapath
        state_d = b_zero ? mdu_pkg::DIV_FINISH : mdu_pkg::DIV_ABS_A;
      end

      mdu_pkg::DIV_ABS_A: begin
        count_d = cnt_first;
        state_d = mdu_pkg::DIV_ABS_B;
      end

      mdu_pkg::DIV_ABS_B: begin
        count_d = cnt_first;
        state_d = mdu_pkg::DIV_COMP;
      end

      mdu_pkg::DIV_COMP: begin
        count_d = count_q - cnt_one;
        state_d = (count_q == cnt_one) ? mdu_pkg::DIV_LAST : mdu_pkg::DIV_COMP;
      end

      mdu_pkg::DIV_LAST: begin
        state_d = mdu_pkg::DIV_SIGN;
      end

      mdu_pkg::DIV_SIGN: begin
        state_d = mdu_pkg::DIV_FINISH;
      end

      mdu_pkg::DIV_FINISH: begin
        // Stay here until the requester takes the result
        valid_o = 1'b1;
        hold    = ~ready_i;
        state_d = mdu_pkg::DIV_IDLE;
      end

      default: begin
        state_d = mdu_pkg::DIV_IDLE;
      end
    endcase
  end

  assign step_o = div_en_i & ~hold;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= mdu_pkg::DIV_IDLE;
      count_q <= '0;
    end else if (step_o) begin
      state_q <= state_d;
      count_q <= count_d;
    end
  end

  assign state_o = state_q;
  assign count_o = count_q;

endmodule

/* hw/div/mdu_div_datapath.sv */
////////////////////////////////////////////////////////////
// Restoring division on absolute values with sign fix-up
// Registers advance only on step_i from the sequencer
////////////////////////////////////////////////////////////

module mdu_div_datapath (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      step_i,
  input  mdu_pkg::div_state_e       state_i,
  input  logic [mdu_pkg::cnt_w-1:0] count_i,
  input  mdu_pkg::md_op_e           operator_i,
  input  logic [1:0]                signed_mode_i,
  input  logic [mdu_pkg::xlen-1:0]  op_a_i,
  input  logic [mdu_pkg::xlen-1:0]  op_b_i,
  output logic [mdu_pkg::xlen-1:0]  result_o
);

  localparam int unsigned xw = mdu_pkg::xlen;

  // Remainder needs one bit above the word after the shift
  logic [xw:0]               rem_q, rem_d;
  logic [xw-1:0]             quo_q, quo_d;
  logic [xw-1:0]             num_q, num_d;
  logic [xw-1:0]             den_q, den_d;
  logic [xw:0]               add_a, add_b;
  logic [xw+1:0]             add_res;
  logic                      ge;
  logic [xw-1:0]             next_rem;
  logic [xw-1:0]             next_quo;
  logic [xw-1:0]             one_shift;
  logic [mdu_pkg::cnt_w-1:0] bit_idx;
  logic                      sign_a, sign_b;
  logic                      is_div;
  logic                      negate;

  assign sign_a = signed_mode_i[0] & op_a_i[xw-1];
  assign sign_b = signed_mode_i[1] & op_b_i[xw-1];
  assign is_div = (operator_i == mdu_pkg::MD_OP_DIV);
  assign negate = is_div ? (sign_a ^ sign_b) : sign_a;

  // Adder computes add_a - x as add_a + ~x + 1
  always_comb begin
    add_a = '0;
    add_b = ~{1'b0, op_b_i};
    unique case (state_i)
      mdu_pkg::DIV_ABS_A: add_b = ~{1'b0, op_a_i};
      mdu_pkg::DIV_COMP,
      mdu_pkg::DIV_LAST: begin
        add_a = rem_q;
        add_b = ~{1'b0, den_q};
      end
      mdu_pkg::DIV_SIGN: add_b = ~{1'b0, rem_q[xw-1:0]};
      default: ;
    endcase
  end

  assign add_res = {1'b0, add_a} + {1'b0, add_b} + {{(xw + 1){1'b0}}, 1'b1};

  // Carry out means the partial remainder covers the denominator
  assign ge        = add_res[xw+1];
  assign next_rem  = ge ? add_res[xw-1:0] : rem_q[xw-1:0];
  assign one_shift = {{(xw - 1){1'b0}}, 1'b1} << count_i;
  assign next_quo  = ge ? (quo_q | one_shift) : quo_q;
  assign bit_idx   = count_i - {{(mdu_pkg::cnt_w - 1){1'b0}}, 1'b1};

  always_comb begin
    rem_d = rem_q;
    quo_d = quo_q;
    num_d = num_q;
    den_d = den_q;

    unique case (state_i)
      mdu_pkg::DIV_IDLE: begin
        // Also the final answer when the divisor is zero
        rem_d = is_div ? '1 : {1'b0, op_a_i};
      end

      mdu_pkg::DIV_ABS_A: begin
        quo_d = '0;
        num_d = sign_a ? add_res[xw-1:0] : op_a_i;
      end

      mdu_pkg::DIV_ABS_B: begin
        rem_d = {{xw{1'b0}}, num_q[xw-1]};
        den_d = sign_b ? add_res[xw-1:0] : op_b_i;
      end

      mdu_pkg::DIV_COMP: begin
        rem_d = {next_rem, num_q[bit_idx]};
        quo_d = next_quo;
      end

      mdu_pkg::DIV_LAST: begin
        rem_d = is_div ? {1'b0, next_quo} : {1'b0, next_rem};
      end

      mdu_pkg::DIV_SIGN: begin
        if (negate) begin
          rem_d = {1'b0, add_res[xw-1:0]};
        end
      end

      default: ;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rem_q <= '0;
      quo_q <= '0;
      num_q <= '0;
      den_q <= '0;
    end else if (step_i) begin
      rem_q <= rem_d;
      quo_q <= quo_d;
      num_q <= num_d;
      den_q <= den_d;
    end
  end

  assign result_o = rem_q[xw-1:0];

endmodule

/* hw/mdu_top.sv */
////////////////////////////////////////////////////////////
// Sequential multiply/divide unit for a 32-bit core
// Enables and operands must stay stable until valid_o and
// ready_i are both high. Only one enable may be high at once
////////////////////////////////////////////////////////////

module mdu_top (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       mult_en_i,
  input  logic                       div_en_i,
  input  logic                       ready_i,
  input  mdu_pkg::md_op_e            operator_i,
  input  logic [1:0]                 signed_mode_i,
  input  logic [mdu_pkg::xlen-1:0]   op_a_i,
  input  logic [mdu_pkg::xlen-1:0]   op_b_i,
  output logic [mdu_pkg::xlen-1:0]   result_o,
  output logic                       valid_o
);

  logic [mdu_pkg::xlen-1:0]  mult_result;
  logic                      mult_valid;
  logic [mdu_pkg::xlen-1:0]  div_result;
  logic                      div_valid;
  logic                      div_step;
  mdu_pkg::div_state_e       div_state;
  logic [mdu_pkg::cnt_w-1:0] div_count;

  mdu_mult_fast u_mult (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .mult_en_i     (mult_en_i),
    .ready_i       (ready_i),
    .operator_i    (operator_i),
    .signed_mode_i (signed_mode_i),
    .op_a_i        (op_a_i),
    .op_b_i        (op_b_i),
    .result_o      (mult_result),
    .valid_o       (mult_valid)
  );

  mdu_div_ctrl u_div_ctrl (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .div_en_i (div_en_i),
    .ready_i  (ready_i),
    .op_b_i   (op_b_i),
    .state_o  (div_state),
    .count_o  (div_count),
    .step_o   (div_step),
    .valid_o  (div_valid)
  );

  mdu_div_datapath u_div_dp (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .step_i        (div_step),
    .state_i       (div_state),
    .count_i       (div_count),
    .operator_i    (operator_i),
    .signed_mode_i (signed_mode_i),
    .op_a_i        (op_a_i),
    .op_b_i        (op_b_i),
    .result_o      (div_result)
  );

  // Divider result only while it is offered
  assign result_o = div_valid ? div_result : mult_result;
  assign valid_o  = mult_valid | div_valid;

endmodule

/* hw/mult/mdu_mult_fast.sv */
////////////////////////////////////////////////////////////
// One 17x17 MAC per cycle, low word in 3 cycles and high
// word in 4. Operands must be held until the result is taken
////////////////////////////////////////////////////////////

module mdu_mult_fast (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     mult_en_i,
  input  logic                     ready_i,
  input  mdu_pkg::md_op_e          operator_i,
  input  logic [1:0]               signed_mode_i,
  input  logic [mdu_pkg::xlen-1:0] op_a_i,
  input  logic [mdu_pkg::xlen-1:0] op_b_i,
  output logic [mdu_pkg::xlen-1:0] result_o,
  output logic                     valid_o
);

  localparam int unsigned xw = mdu_pkg::xlen;
  localparam int unsigned hw = mdu_pkg::half_w;
  localparam int unsigned aw = mdu_pkg::acc_w;

  typedef enum logic [1:0] {
    ALBL,
    ALBH,
    AHBL,
    AHBH
  } mult_state_e;

  mult_state_e         state_q, state_d;
  logic [aw-1:0]       acc_q;
  logic [aw-1:0]       accum;
  logic [aw-1:0]       mac_res;
  logic [aw-1:0]       mac_res_d;
  logic signed [aw:0]  mac_res_signed;
  logic [hw-1:0]       mult_op_a, mult_op_b;
  logic                sign_a, sign_b;
  logic                signed_mult;
  logic                hold;

  assign signed_mult = (signed_mode_i != 2'b00);

  // The top two bits of the 35-bit sum always agree, so bit aw is dropped
  assign mac_res_signed = $signed({sign_a, mult_op_a}) * $signed({sign_b, mult_op_b})
                        + $signed(accum);
  assign mac_res = mac_res_signed[aw-1:0];

  always_comb begin
    mult_op_a = op_a_i[hw-1:0];
    mult_op_b = op_b_i[hw-1:0];
    sign_a    = 1'b0;
    sign_b    = 1'b0;
    accum     = '0;
    mac_res_d = mac_res;
    state_d   = state_q;
    valid_o   = 1'b0;
    hold      = 1'b0;

    unique case (state_q)
      ALBL: begin
        state_d = ALBH;
      end

      ALBH: begin
        // al * bh, shifted down by the low half of al * bl
        mult_op_b = op_b_i[xw-1:hw];
        sign_b    = signed_mode_i[1] & op_b_i[xw-1];
        accum     = {{(aw - hw){1'b0}}, acc_q[xw-1:hw]};
        if (operator_i == mdu_pkg::MD_OP_MULL) begin
          mac_res_d = {2'b00, mac_res[hw-1:0], acc_q[hw-1:0]};
        end
        state_d = AHBL;
      end

      AHBL: begin
        mult_op_a = op_a_i[xw-1:hw];
        sign_a    = signed_mode_i[0] & op_a_i[xw-1];
        if (operator_i == mdu_pkg::MD_OP_MULL) begin
          // Low word done, splice the kept low half under the new sum
          accum     = {{(aw - hw){1'b0}}, acc_q[xw-1:hw]};
          mac_res_d = {2'b00, mac_res[hw-1:0], acc_q[hw-1:0]};
          valid_o   = 1'b1;
          hold      = ~ready_i;
          state_d   = ALBL;
        end else begin
          accum   = acc_q;
          state_d = AHBH;
        end
      end

      AHBH: begin
        mult_op_a = op_a_i[xw-1:hw];
        mult_op_b = op_b_i[xw-1:hw];
        sign_a    = signed_mode_i[0] & op_a_i[xw-1];
        sign_b    = signed_mode_i[1] & op_b_i[xw-1];
        // Upper part of the running sum, sign extended unless fully unsigned
        accum[aw-hw-1:0]  = acc_q[aw-1:hw];
        accum[aw-1:aw-hw] = {hw{signed_mult & acc_q[aw-1]}};
        valid_o = 1'b1;
        hold    = ~ready_i;
        state_d = ALBL;
      end

      default: begin
        state_d = ALBL;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ALBL;
      acc_q   <= '0;
    end else if (mult_en_i && !hold) begin
      state_q <= state_d;
      acc_q   <= mac_res_d;
    end
  end

  assign result_o = mac_res_d[xw-1:0];

endmodule

/* verif/mdu_tb_tasks.svh */
////////////////////////////////////////////////////////////
// Directed test tasks, included inside the testbench module
// Relies on the testbench signals and check helpers
////////////////////////////////////////////////////////////

task automatic drive_op(input mdu_pkg::md_op_e op, input logic [1:0] mode,
                        input logic [31:0] a, input logic [31:0] b, input logic rdy);
  @(posedge clk_i);
  mult_en_i     <= (op == mdu_pkg::MD_OP_MULL) || (op == mdu_pkg::MD_OP_MULH);
  div_en_i      <= (op == mdu_pkg::MD_OP_DIV) || (op == mdu_pkg::MD_OP_REM);
  operator_i    <= op;
  signed_mode_i <= mode;
  op_a_i        <= a;
  op_b_i        <= b;
  ready_i       <= rdy;
endtask

task automatic wait_for_valid(output int cyc);
  logic seen;
  cyc  = 0;
  seen = 1'b0;
  while (!seen && cyc < 64) begin
    @(negedge clk_i);
    cyc++;
    seen = valid_o;
  end
  if (!seen) begin
    abort_run("valid_o did not rise within 64 cycles of the enable");
  end
endtask

// Handshake completes on this edge, then the unit must be idle
task automatic release_op();
  @(posedge clk_i);
  mult_en_i <= 1'b0;
  div_en_i  <= 1'b0;
  @(negedge clk_i);
  assert (valid_o === 1'b0) else report_mismatch("valid_o", 32'h0, valid_o);
endtask

task automatic run_op(input mdu_pkg::md_op_e op, input logic [1:0] mode,
                      input logic [31:0] a, input logic [31:0] b);
  logic [31:0] expected;
  int          cyc;
  expected = model_result(op, mode, a, b);
  drive_op(op, mode, a, b, 1'b1);
  wait_for_valid(cyc);
  assert (cyc == expected_cycles(op, b))
    else report_mismatch("valid_o cycle", expected_cycles(op, b), cyc);
  assert (result_o === expected) else report_mismatch("result_o", expected, result_o);
  release_op();
endtask

// Result is offered with ready_i low, which must freeze it
task automatic run_held_op(input mdu_pkg::md_op_e op, input logic [1:0] mode,
                           input logic [31:0] a, input logic [31:0] b);
  logic [31:0] expected;
  int          cyc;
  int          hold_n;
  expected = model_result(op, mode, a, b);
  hold_n   = 1 + ($urandom % 8);
  drive_op(op, mode, a, b, 1'b0);
  wait_for_valid(cyc);
  assert (cyc == expected_cycles(op, b))
    else report_mismatch("valid_o cycle", expected_cycles(op, b), cyc);
  assert (result_o === expected) else report_mismatch("result_o", expected, result_o);
  repeat (hold_n) begin
    @(negedge clk_i);
    assert (valid_o === 1'b1) else report_mismatch("valid_o", 32'h1, valid_o);
    assert (result_o === expected) else report_mismatch("result_o", expected, result_o);
  end
  @(posedge clk_i);
  ready_i <= 1'b1;
  @(negedge clk_i);
  assert (valid_o === 1'b1) else report_mismatch("valid_o", 32'h1, valid_o);
  assert (result_o === expected) else report_mismatch("result_o", expected, result_o);
  release_op();
endtask

task automatic check_idle_after_reset();
  repeat (5) begin
    @(negedge clk_i);
    assert (valid_o === 1'b0) else report_mismatch("valid_o", 32'h0, valid_o);
  end
endtask

task automatic run_mult_set(input mdu_pkg::md_op_e op, input logic [1:0] mode);
  int i;
  int j;
  for (i = 0; i < 4; i++) begin
    for (j = 0; j < 4; j++) begin
      run_op(op, mode, corners[i], corners[j]);
    end
  end
  for (i = 0; i < 20; i++) begin
    run_op(op, mode, rand_a[i], rand_b[i]);
  end
endtask

task automatic test_mull();
  run_mult_set(mdu_pkg::MD_OP_MULL, 2'b00);
endtask

task automatic test_mulh();
  run_mult_set(mdu_pkg::MD_OP_MULH, 2'b11);
  run_mult_set(mdu_pkg::MD_OP_MULH, 2'b01);
  run_mult_set(mdu_pkg::MD_OP_MULH, 2'b00);
endtask

task automatic run_div_set(input logic [31:0] a, input logic [31:0] b);
  run_op(mdu_pkg::MD_OP_DIV, 2'b11, a, b);
  run_op(mdu_pkg::MD_OP_REM, 2'b11, a, b);
  run_op(mdu_pkg::MD_OP_DIV, 2'b00, a, b);
  run_op(mdu_pkg::MD_OP_REM, 2'b00, a, b);
endtask

task automatic test_div_rem();
  int          i;
  logic [31:0] a;
  logic [31:0] b;
  for (i = 0; i < 10; i++) begin
    run_div_set(div_a[i], div_b[i]);
  end
  // Random divisors of varied magnitude, never zero
  for (i = 0; i < 6; i++) begin
    a = $urandom;
    b = $urandom >> ($urandom % 28);
    if (b == 32'h0) begin
      b = 32'h1;
    end
    run_div_set(a, b);
  end
endtask

task automatic test_div_by_zero();
  run_div_set(32'h8765_4321, 32'h0);
endtask

task automatic test_backpressure();
  run_held_op(mdu_pkg::MD_OP_MULH, 2'b11, rand_a[3], rand_b[3]);
  run_held_op(mdu_pkg::MD_OP_DIV, 2'b11, rand_a[7], 32'hffff_ff13);
endtask

/* verif/mdu_tb.sv */
////////////////////////////////////////////////////////////
// Directed testbench for the multiply/divide unit
// Inputs change on the rising edge, outputs are sampled on
// the falling edge. The first error ends the run
////////////////////////////////////////////////////////////

module mdu_tb;

  localparam int max_cycles = 6000;

  logic                     clk_i;
  logic                     rst_ni;
  logic                     mult_en_i;
  logic                     div_en_i;
  logic                     ready_i;
  mdu_pkg::md_op_e          operator_i;
  logic [1:0]               signed_mode_i;
  logic [mdu_pkg::xlen-1:0] op_a_i;
  logic [mdu_pkg::xlen-1:0] op_b_i;
  logic [mdu_pkg::xlen-1:0] result_o;
  logic                     valid_o;

  int          cycle_cnt;
  logic [31:0] rand_a [0:19];
  logic [31:0] rand_b [0:19];
  logic [31:0] corners [0:3] = '{32'h0000_0000, 32'h0000_0001, 32'hffff_ffff, 32'h8000_0000};

  // Division pairs with mixed signs and the signed overflow case
  logic [31:0] div_a [0:9] = '{32'd7, 32'hffff_fff9, 32'd7, 32'hffff_fff9, 32'h8000_0000,
                               32'h8000_0000, 32'hffff_ffff, 32'd1, 32'hffff_ffff, 32'd100};
  logic [31:0] div_b [0:9] = '{32'd2, 32'd2, 32'hffff_fffe, 32'hffff_fffe, 32'hffff_ffff,
                               32'd1, 32'd1, 32'hffff_ffff, 32'd3, 32'd7};

  mdu_top u_dut (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .mult_en_i     (mult_en_i),
    .div_en_i      (div_en_i),
    .ready_i       (ready_i),
    .operator_i    (operator_i),
    .signed_mode_i (signed_mode_i),
    .op_a_i        (op_a_i),
    .op_b_i        (op_b_i),
    .result_o      (result_o),
    .valid_o       (valid_o)
  );

  always #20 clk_i = ~clk_i;

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
    $display("CHECK FAILED at time %0t: %s expected 0x%08h, got 0x%08h", $time, name, exp, act);
    $display("Result: FAILED");
    $fatal(1);
  endtask

  task automatic abort_run(input string reason);
    $display("Error at time %0t: %s", $time, reason);
    $display("Result: FAILED");
    $fatal(1);
  endtask

  // Global limit against a stuck handshake
  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= max_cycles) begin
      abort_run("the run did not finish within the cycle limit");
    end
  end

  // RISC-V results for products, truncating division and the special cases
  function automatic logic [31:0] model_result(input mdu_pkg::md_op_e op,
                                               input logic [1:0] mode,
                                               input logic [31:0] a, input logic [31:0] b);
    logic [63:0]        ext_a, ext_b, prod;
    logic signed [31:0] sa, sb;
    logic [31:0]        q, r;
    ext_a = mode[0] ? {{32{a[31]}}, a} : {32'h0, a};
    ext_b = mode[1] ? {{32{b[31]}}, b} : {32'h0, b};
    prod  = ext_a * ext_b;
    sa    = a;
    sb    = b;
    if (b == 32'h0) begin
      q = 32'hffff_ffff;
      r = a;
    end else if (mode == 2'b11) begin
      if (a == 32'h8000_0000 && b == 32'hffff_ffff) begin
        q = 32'h8000_0000;
        r = 32'h0;
      end else begin
        q = sa / sb;
        r = sa % sb;
      end
    end else begin
      q = a / b;
      r = a % b;
    end
    case (op)
      mdu_pkg::MD_OP_MULL: return prod[31:0];
      mdu_pkg::MD_OP_MULH: return prod[63:32];
      mdu_pkg::MD_OP_DIV:  return q;
      default:             return r;
    endcase
  endfunction

  // Cycle in which valid_o first rises
  function automatic int expected_cycles(input mdu_pkg::md_op_e op, input logic [31:0] b);
    case (op)
      mdu_pkg::MD_OP_MULL: return 3;
      mdu_pkg::MD_OP_MULH: return 4;
      default:             return (b == 32'h0) ? 2 : 37;
    endcase
  endfunction

  `include "mdu_tb_tasks.svh"

  initial begin
    int i;
    clk_i         = 1'b0;
    rst_ni        = 1'b0;
    mult_en_i     = 1'b0;
    div_en_i      = 1'b0;
    ready_i       = 1'b1;
    operator_i    = mdu_pkg::MD_OP_MULL;
    signed_mode_i = 2'b00;
    op_a_i        = '0;
    op_b_i        = '0;
    cycle_cnt     = 0;
    void'($urandom(32'h8561_1fbe));
    for (i = 0; i < 20; i++) begin
      rand_a[i] = $urandom;
      rand_b[i] = $urandom;
    end

    repeat (10) @(posedge clk_i);
    rst_ni <= 1'b1;

    check_idle_after_reset();
    test_mull();
    test_mulh();
    test_div_rem();
    test_div_by_zero();
    test_backpressure();

    $display("Result: PASSED");
    $finish;
  end

endmodule
